// File: files.f
hdl/cpu_types_pkg.sv
hdl/bpu_pkg.sv
hdl/two_level_predictor.sv
hdl/branch_target_buffer.sv
hdl/return_addr_stack.sv
hdl/return_site_table.sv
hdl/branch_predictor.sv
testbench/tb_branch_predictor.sv

// File: hdl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // Prediction handed to the first fetch stage.
    typedef struct packed {
        logic                 hit;
        logic                 taken;
        cpu_types_pkg::addr_t target;
    } fetch_pred_t;

    // One line of the branch target buffer.
    // The tag keeps the whole word address, so the index bits are
    // checked twice. That keeps the compare independent of table size.
    typedef struct packed {
        logic                 valid;
        logic                 is_jump; // J or JAL, always taken.
        logic [29:0]          tag;     // Address bits [31:2].
        cpu_types_pkg::addr_t target;
    } btb_entry_t;

endpackage

`default_nettype wire

// File: hdl/branch_predictor.sv
`default_nettype none

module branch_predictor #(
    parameter int PHT_ENTRIES   = 64,
    parameter int COUNTER_BITS  = 2,
    parameter int BTB_ENTRIES   = 16,
    parameter int RAS_DEPTH     = 8,
    parameter int RSITE_ENTRIES = 8
) (
    input  logic                        clk,
    input  logic                        reset,

    input  cpu_types_pkg::addr_t        f1_pc,   // First fetch stage.
    output bpu_pkg::fetch_pred_t        f1_pred,

    input  logic                        need_pre, // Conditional branch in decode.
    input  logic                        is_jr_ra_decode,
    output logic                        decode_taken,

    input  cpu_types_pkg::exe_update_t  exe
);

    import cpu_types_pkg::*;

    logic  pht_update;
    logic  btb_write;
    logic  btb_write_jump;
    logic  ras_push;
    logic  ras_pop;
    logic  rsite_write;

    logic  direction;
    logic  btb_hit;
    logic  btb_jump;
    logic  rsite_hit;
    addr_t btb_target;
    addr_t ras_top;

    // Execute kind to update strobes.
    always_comb begin
        pht_update     = 1'b0;
        btb_write      = 1'b0;
        btb_write_jump = 1'b0;
        ras_push       = 1'b0;
        rsite_write    = 1'b0;
        case (exe.kind)
            BR_COND: begin
                pht_update = 1'b1;
                btb_write  = 1'b1;
            end
            BR_J: begin
                btb_write      = 1'b1;
                btb_write_jump = 1'b1;
            end
            BR_JAL: begin
                btb_write      = 1'b1;
                btb_write_jump = 1'b1;
                ras_push       = 1'b1;
            end
            BR_JALR:  ras_push    = 1'b1;
            BR_JR_RA: rsite_write = 1'b1;
            default: ;
        endcase
    end

    assign ras_pop = is_jr_ra_decode | rsite_hit;

    // Fetch prediction.
    assign f1_pred.hit = btb_hit | rsite_hit;

    always_comb begin
        f1_pred.target = '0;
        if (btb_hit) begin
            f1_pred.target = btb_target;
        end else if (rsite_hit || is_jr_ra_decode) begin
            f1_pred.target = ras_top;
        end
    end

    always_comb begin
        f1_pred.taken = 1'b0;
        if (rsite_hit) begin
            f1_pred.taken = 1'b1;
        end else if (btb_hit) begin
            f1_pred.taken = btb_jump | direction; // Jumps are always taken.
        end
    end

    assign decode_taken = need_pre & direction;

    two_level_predictor #(
        .PHT_ENTRIES (PHT_ENTRIES),
        .COUNTER_BITS(COUNTER_BITS)
    ) u_pht (
        .clk,
        .reset,
        .update   (pht_update),
        .taken    (exe.taken),
        .direction(direction)
    );

    branch_target_buffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_btb (
        .clk,
        .reset,
        .lookup_pc   (f1_pc),
        .hit         (btb_hit),
        .is_jump     (btb_jump),
        .target      (btb_target),
        .write       (btb_write),
        .write_jump  (btb_write_jump),
        .write_pc    (exe.pc),
        .write_target(exe.dest)
    );

    return_addr_stack #(
        .RAS_DEPTH(RAS_DEPTH)
    ) u_ras (
        .clk,
        .reset,
        .push     (ras_push),
        .pop      (ras_pop),
        .push_addr(exe.ret),
        .top      (ras_top)
    );

    return_site_table #(
        .RSITE_ENTRIES(RSITE_ENTRIES)
    ) u_rsite (
        .clk,
        .reset,
        .write    (rsite_write),
        .write_pc (exe.pc),
        .lookup_pc(f1_pc),
        .hit      (rsite_hit)
    );

endmodule

`default_nettype wire

// File: hdl/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic                 clk,
    input  logic                 reset,

    input  cpu_types_pkg::addr_t lookup_pc,
    output logic                 hit,
    output logic                 is_jump,
    output cpu_types_pkg::addr_t target,

    input  logic                 write,
    input  logic                 write_jump,
    input  cpu_types_pkg::addr_t write_pc,
    input  cpu_types_pkg::addr_t write_target
);

    import bpu_pkg::*;

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);

    btb_entry_t          entries [BTB_ENTRIES];
    btb_entry_t          rd_entry;
    btb_entry_t          wr_entry;
    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;

    // Lookup side.
    assign rd_idx   = lookup_pc[2 +: IDX_BITS];
    assign rd_entry = entries[rd_idx];

    assign hit     = rd_entry.valid && (rd_entry.tag == lookup_pc[31:2]);
    assign is_jump = rd_entry.is_jump; // Only meaningful on a hit.
    assign target  = rd_entry.target;

    // Write side, a whole line is replaced.
    assign wr_idx = write_pc[2 +: IDX_BITS];

    always_comb begin
        wr_entry.valid   = 1'b1;
        wr_entry.is_jump = write_jump;
        wr_entry.tag     = write_pc[31:2];
        wr_entry.target  = write_target;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0; // Tag and target keep their contents.
            end
        end else if (write) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    // Aliasing branches simply evict each other.

endmodule

`default_nettype wire

// File: hdl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    // Instruction address, byte granular.
    typedef logic [31:0] addr_t;

    // Kind of control transfer resolved in execute this cycle.
    typedef enum logic [2:0] {
        BR_NONE  = 3'd0,
        BR_COND  = 3'd1, // beq, bne and friends.
        BR_J     = 3'd2,
        BR_JAL   = 3'd3,
        BR_JALR  = 3'd4,
        BR_JR_RA = 3'd5  // Function return.
    } branch_kind_t;

    // Resolved outcome sent back from execute.
    // Any kind other than BR_NONE is a one-cycle strobe.
    typedef struct packed {
        branch_kind_t kind;
        logic         taken;
        addr_t        pc;   // Address of the resolved instruction.
        addr_t        dest; // Resolved target.
        addr_t        ret;  // Link address, pc + 8.
    } exe_update_t;

endpackage

`default_nettype wire

// File: hdl/return_addr_stack.sv
`default_nettype none

module return_addr_stack #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,      // JAL or JALR resolved.
    input  logic                 pop,       // Return seen in fetch or decode.
    input  cpu_types_pkg::addr_t push_addr,
    output cpu_types_pkg::addr_t top
);

    import cpu_types_pkg::*;

    localparam int PTR_BITS = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

    addr_t               stack [RAS_DEPTH];
    logic [PTR_BITS-1:0] ptr;      // Next free slot.
    logic [PTR_BITS-1:0] top_idx;
    logic [PTR_BITS-1:0] next_idx;

    // Circular pointer, explicit wrap so any depth works.
    assign top_idx  = (ptr == '0) ? PTR_BITS'(RAS_DEPTH - 1) : ptr - 1'b1;
    assign next_idx = (ptr == PTR_BITS'(RAS_DEPTH - 1)) ? '0 : ptr + 1'b1;

    assign top = stack[top_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
        end else begin
            case ({push, pop})
                2'b11: stack[top_idx] <= push_addr; // Replace top.
                2'b10: begin
                    stack[ptr] <= push_addr; // Oldest entry lost on overflow.
                    ptr        <= next_idx;
                end
                2'b01: ptr <= top_idx;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/return_site_table.sv
`default_nettype none

module return_site_table #(
    parameter int RSITE_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write,     // jr ra resolved in execute.
    input  cpu_types_pkg::addr_t write_pc,
    input  cpu_types_pkg::addr_t lookup_pc,
    output logic                 hit
);

    localparam int IDX_BITS = $clog2(RSITE_ENTRIES);

    logic                valid [RSITE_ENTRIES];
    logic [29:0]         tags  [RSITE_ENTRIES]; // Word address bits [31:2].
    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;

    assign rd_idx = lookup_pc[2 +: IDX_BITS];
    assign wr_idx = write_pc[2 +: IDX_BITS];

    // Fetch can redirect a return before decode sees it.
    assign hit = valid[rd_idx] && (tags[rd_idx] == lookup_pc[31:2]);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RSITE_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (write) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            tags[wr_idx] <= write_pc[31:2];
        end
    end

endmodule

`default_nettype wire

// File: hdl/two_level_predictor.sv
`default_nettype none

module two_level_predictor #(
    parameter int PHT_ENTRIES  = 64,
    parameter int COUNTER_BITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic update,   // Conditional branch resolved.
    input  logic taken,
    output logic direction // 1 means taken.
);

    localparam int HIST_BITS = $clog2(PHT_ENTRIES);
    localparam logic [COUNTER_BITS-1:0] WEAK_NT = COUNTER_BITS'((1 << (COUNTER_BITS - 1)) - 1);
    localparam logic [COUNTER_BITS-1:0] CNT_MAX = '1;

    logic [HIST_BITS-1:0]    history;
    logic [COUNTER_BITS-1:0] pht [PHT_ENTRIES];
    logic [COUNTER_BITS-1:0] cnt;

    // History alone selects the counter, no pc bits are hashed in.
    assign cnt       = pht[history];
    assign direction = cnt[COUNTER_BITS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= WEAK_NT;
            end
        end else if (update) begin
            // Saturating train of the counter used for the prediction.
            if (taken && cnt != CNT_MAX) begin
                pht[history] <= cnt + 1'b1;
            end else if (!taken && cnt != '0) begin
                pht[history] <= cnt - 1'b1;
            end
            history <= HIST_BITS'({history, taken}); // Newest outcome in the LSB.
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_branch_predictor.sv
`default_nettype none

module tb_branch_predictor;

    timeunit 1ns;
    timeprecision 100ps;

    import cpu_types_pkg::*;
    import bpu_pkg::*;

    localparam int PHT_ENTRIES   = 64;
    localparam int COUNTER_BITS  = 2;
    localparam int BTB_ENTRIES   = 16;
    localparam int RAS_DEPTH     = 8;
    localparam int RSITE_ENTRIES = 8;
    localparam int HIST_BITS     = $clog2(PHT_ENTRIES);
    localparam int POOL_SIZE     = 24;
    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_CYCLES    = 3000;
    localparam addr_t OFF_PC     = 32'h0000_0f00; // Never written to any table.

    logic        clk;
    logic        reset;
    addr_t       f1_pc;
    fetch_pred_t f1_pred;
    logic        need_pre;
    logic        is_jr_ra_decode;
    logic        decode_taken;
    exe_update_t exe;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    addr_t       pool [POOL_SIZE];

    // Reference model.
    btb_entry_t              m_btb      [BTB_ENTRIES];
    logic                    m_rs_valid [RSITE_ENTRIES];
    logic [29:0]             m_rs_tag   [RSITE_ENTRIES];
    logic [HIST_BITS-1:0]    m_hist;
    logic [COUNTER_BITS-1:0] m_pht      [PHT_ENTRIES];
    addr_t                   m_ras      [RAS_DEPTH];
    int                      m_ptr;

    // Last values sampled from the DUT.
    logic  got_hit;
    logic  got_taken;
    logic  got_dec;
    addr_t got_target;

    branch_predictor u_dut (
        .clk,
        .reset,
        .f1_pc,
        .f1_pred,
        .need_pre,
        .is_jr_ra_decode,
        .decode_taken,
        .exe
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing.", cycle_count);
            $display("Testbench failed");
            $fatal(1, "Timeout.");
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:8] % n); // Low LCG bits have short periods.
    endfunction

    function automatic exe_update_t make_exe(branch_kind_t kind, logic taken,
                                             addr_t pc, addr_t dest);
        exe_update_t e;
        e.kind  = kind;
        e.taken = taken;
        e.pc    = pc;
        e.dest  = dest;
        e.ret   = pc + 32'd8;
        return e;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at first mismatch.");
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_btb[i] = '0;
        end
        for (int i = 0; i < RSITE_ENTRIES; i++) begin
            m_rs_valid[i] = 1'b0;
            m_rs_tag[i]   = '0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_pht[i] = COUNTER_BITS'((1 << (COUNTER_BITS - 1)) - 1); // Weakly not-taken.
        end
        for (int i = 0; i < RAS_DEPTH; i++) begin
            m_ras[i] = '0;
        end
        m_hist = '0;
        m_ptr  = 0;
    endtask

    task automatic predict(input addr_t pc, input logic np, input logic jr,
                           output logic hit, output logic taken, output addr_t target,
                           output logic dec, output logic pop);
        int   bi;
        int   ri;
        logic btb_hit;
        logic rs_hit;
        logic dir;
        bi      = (pc >> 2) % BTB_ENTRIES;
        ri      = (pc >> 2) % RSITE_ENTRIES;
        btb_hit = m_btb[bi].valid && (m_btb[bi].tag == pc[31:2]);
        rs_hit  = m_rs_valid[ri] && (m_rs_tag[ri] == pc[31:2]);
        dir     = m_pht[m_hist][COUNTER_BITS-1];
        hit     = btb_hit || rs_hit;
        if (btb_hit) begin
            target = m_btb[bi].target;
        end else if (rs_hit || jr) begin
            target = m_ras[(m_ptr + RAS_DEPTH - 1) % RAS_DEPTH];
        end else begin
            target = '0;
        end
        if (rs_hit) begin
            taken = 1'b1;
        end else if (btb_hit) begin
            taken = m_btb[bi].is_jump || dir;
        end else begin
            taken = 1'b0;
        end
        dec = np && dir;
        pop = jr || rs_hit;
    endtask

    task automatic model_update(input exe_update_t e, input logic pop);
        int   top;
        int   bi;
        int   ri;
        logic push;
        top  = (m_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
        push = e.kind inside {BR_JAL, BR_JALR};
        if (e.kind == BR_COND) begin
            if (e.taken && m_pht[m_hist] != '1) begin
                m_pht[m_hist] = m_pht[m_hist] + 1'b1;
            end else if (!e.taken && m_pht[m_hist] != '0) begin
                m_pht[m_hist] = m_pht[m_hist] - 1'b1;
            end
            m_hist = {m_hist[HIST_BITS-2:0], e.taken};
        end
        if (e.kind inside {BR_COND, BR_J, BR_JAL}) begin
            bi                = (e.pc >> 2) % BTB_ENTRIES;
            m_btb[bi].valid   = 1'b1;
            m_btb[bi].is_jump = (e.kind != BR_COND);
            m_btb[bi].tag     = e.pc[31:2];
            m_btb[bi].target  = e.dest;
        end
        if (e.kind == BR_JR_RA) begin
            ri             = (e.pc >> 2) % RSITE_ENTRIES;
            m_rs_valid[ri] = 1'b1;
            m_rs_tag[ri]   = e.pc[31:2];
        end
        if (push && pop) begin
            m_ras[top] = e.ret;
        end else if (push) begin
            m_ras[m_ptr] = e.ret;
            m_ptr        = (m_ptr + 1) % RAS_DEPTH;
        end else if (pop) begin
            m_ptr = top;
        end
    endtask

    // One clock: drive on the falling edge, check, then advance the model.
    task automatic run_cycle(input addr_t pc, input logic np, input logic jr,
                             input exe_update_t e);
        logic  exp_hit;
        logic  exp_taken;
        logic  exp_dec;
        logic  pop;
        addr_t exp_target;
        @(negedge clk);
        f1_pc           = pc;
        need_pre        = np;
        is_jr_ra_decode = jr;
        exe             = e;
        predict(pc, np, jr, exp_hit, exp_taken, exp_target, exp_dec, pop);
        #1;
        got_hit    = f1_pred.hit;
        got_taken  = f1_pred.taken;
        got_target = f1_pred.target;
        got_dec    = decode_taken;
        check(got_hit, exp_hit, "f1_pred.hit");
        check(got_taken, exp_taken, "f1_pred.taken");
        check(got_target, exp_target, "f1_pred.target");
        check(got_dec, exp_dec, "decode_taken");
        @(posedge clk);
        model_update(e, pop);
    endtask

    task automatic fetch_only(input addr_t pc, input logic np, input logic jr);
        run_cycle(pc, np, jr, make_exe(BR_NONE, 1'b0, '0, '0));
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        model_reset();
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 16; i++) begin
            fetch_only(pool[rand_below(POOL_SIZE)], rand_below(2) == 1, 1'b0);
            check(got_hit, 1'b0, "hit after reset");
            check(got_taken, 1'b0, "taken after reset");
            check(got_dec, 1'b0, "decode_taken after reset");
            check(got_target, '0, "target after reset");
        end
    endtask

    task automatic target_buffer_writes();
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_J, 1'b1, pool[0], 32'h0040_8000));
        fetch_only(pool[0], 1'b0, 1'b0);
        check(got_hit, 1'b1, "BTB hit after J");
        check(got_taken, 1'b1, "J taken with not-taken counter");
        check(got_target, 32'h0040_8000, "BTB target after J");
        // pool[12] shares the index of pool[0].
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_COND, 1'b0, pool[12], 32'h0040_9000));
        fetch_only(pool[12], 1'b0, 1'b0);
        check(got_target, 32'h0040_9000, "BTB target after aliasing write");
        fetch_only(pool[0], 1'b0, 1'b0);
        check(got_hit, 1'b0, "evicted BTB entry");
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JAL, 1'b1, pool[1], 32'h0040_a000));
        fetch_only(pool[1], 1'b0, 1'b0);
        check(got_taken, 1'b1, "JAL taken");
    endtask

    task automatic direction_training();
        for (int i = 0; i < 12; i++) begin
            run_cycle(pool[2], 1'b1, 1'b0, make_exe(BR_COND, 1'b1, pool[2], 32'h0040_b000));
        end
        fetch_only(pool[2], 1'b1, 1'b0);
        check(got_dec, 1'b1, "decode_taken after taken run");
        check(got_taken, 1'b1, "branch taken after taken run");
    endtask

    task automatic return_stack_order();
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JAL, 1'b1, pool[3], 32'h0041_0000));
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JALR, 1'b1, pool[4], 32'h0041_1000));
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JAL, 1'b1, pool[5], 32'h0041_2000));
        for (int i = 5; i >= 3; i--) begin
            fetch_only(OFF_PC, 1'b0, 1'b1);
            check(got_target, pool[i] + 32'd8, "return address order");
        end
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JAL, 1'b1, pool[6], 32'h0041_3000));
        run_cycle(OFF_PC, 1'b0, 1'b1, make_exe(BR_JALR, 1'b1, pool[7], 32'h0041_4000));
        fetch_only(OFF_PC, 1'b0, 1'b1);
        check(got_target, pool[7] + 32'd8, "top replaced by push with pop");
        for (int i = 0; i < RAS_DEPTH + 3; i++) begin
            run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JALR, 1'b1, pool[8 + i], '0));
        end
        // Only the last RAS_DEPTH pushes survive and later pops come round again.
        for (int i = 0; i < RAS_DEPTH + 3; i++) begin
            fetch_only(OFF_PC, 1'b0, 1'b1);
            check(got_target, pool[8 + RAS_DEPTH + 2 - (i % RAS_DEPTH)] + 32'd8,
                  "wrapped return address");
        end
    endtask

    task automatic return_site_redirect();
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JR_RA, 1'b1, pool[20], '0));
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JALR, 1'b1, pool[19], 32'h0041_f000));
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_JAL, 1'b1, pool[21], 32'h0042_0000));
        fetch_only(pool[20], 1'b0, 1'b0);
        check(got_hit, 1'b1, "return site hit");
        check(got_taken, 1'b1, "return site taken");
        check(got_target, pool[21] + 32'd8, "return site target");
        fetch_only(OFF_PC, 1'b0, 1'b1);
        check(got_target, pool[19] + 32'd8, "stack popped by return site");
        run_cycle(OFF_PC, 1'b0, 1'b0, make_exe(BR_J, 1'b1, pool[20], 32'h0043_0000));
        fetch_only(pool[20], 1'b0, 1'b0);
        check(got_target, 32'h0043_0000, "BTB target over return site");
    endtask

    task automatic random_mix();
        addr_t        pc;
        logic         np;
        logic         jr;
        branch_kind_t kind;
        exe_update_t  e;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            pc   = pool[rand_below(POOL_SIZE)];
            np   = (rand_below(2) == 1);
            jr   = (rand_below(4) == 0); // Keeps the stack from draining every cycle.
            kind = branch_kind_t'(rand_below(6));
            e    = make_exe(kind, rand_below(2) == 1, pool[rand_below(POOL_SIZE)],
                            next_rand() & 32'hffff_fffc);
            run_cycle(pc, np, jr, e);
        end
    endtask

    initial begin
        rng_state       = 32'h8c08_67af;
        reset           = 1'b1;
        f1_pc           = '0;
        need_pre        = 1'b0;
        is_jr_ra_decode = 1'b0;
        exe             = '0;
        // Entries i and i + 12 alias in the BTB.
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = 32'h0040_0000 + 32'((i % 12) * 4) + 32'((i / 12) * 32'h100);
        end
        apply_reset();
        idle_after_reset();
        target_buffer_writes();
        direction_training();
        return_stack_order();
        return_site_redirect();
        random_mix();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
